//--- logic/afu_pkg.sv
`default_nettype none

package afu_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_SOURCES   = 4;   // restart, wed, write, read
  localparam int TAG_WIDTH     = 8;
  localparam int ADDRESS_WIDTH = 64;  // effective address
  localparam int SIZE_WIDTH    = 12;  // bytes
  localparam int CODE_WIDTH    = 13;

  //////////////////////////////////////////////////////////////////////
  // basic types
  //////////////////////////////////////////////////////////////////////

  // host command codes, subset used by this unit
  typedef enum logic [CODE_WIDTH-1:0] {
    INVALID    = 13'h0000,
    RESTART    = 13'h0001,  // context restart
    READ_CL_NA = 13'h0a00,  // read line, no allocate
    WRITE_NA   = 13'h0d00   // write, no allocate
  } command_code_t;

  typedef enum logic [2:0] {
    STRICT = 3'b000         // abort on any translation fault
  } abort_mode_t;

  typedef logic [TAG_WIDTH-1:0]     tag_t;
  typedef logic [ADDRESS_WIDTH-1:0] address_t;
  typedef logic [SIZE_WIDTH-1:0]    size_t;
  typedef logic [1:0]               request_source_t;

  localparam tag_t INVALID_TAG = '1;

  // source index, lower wins
  localparam request_source_t RESTART_SOURCE = 2'd0;
  localparam request_source_t WED_SOURCE     = 2'd1;
  localparam request_source_t WRITE_SOURCE   = 2'd2;
  localparam request_source_t READ_SOURCE    = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // command structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic          valid;
    command_code_t command;
    address_t      address;
    size_t         size;
  } command_buffer_line_t;

  typedef struct packed {
    logic          valid;
    command_code_t command;
    logic          command_parity;
    address_t      address;
    logic          address_parity;
    tag_t          tag;
    logic          tag_parity;
    size_t         size;
    abort_mode_t   abt;
    logic [15:0]   context_handle;  // dedicated mode, always zero
  } command_interface_output_t;

  // wed descriptor fetch and reads share the same bus command
  localparam command_code_t SOURCE_CODE [NUM_SOURCES] = '{
    RESTART_SOURCE: RESTART,
    WED_SOURCE:     READ_CL_NA,
    WRITE_SOURCE:   WRITE_NA,
    READ_SOURCE:    READ_CL_NA
  };

  // set when data holds an even count of ones, narrower fields zero extend
  function automatic logic odd_parity(input address_t data);
    return ~(^data);
  endfunction

endpackage

`default_nettype wire

//--- logic/cmd_line_if.sv
`timescale 1ns/1ps
`default_nettype none

// selected command line, one cycle wide, arbiter to command control
interface cmd_line_if ();
  import afu_pkg::*;

  command_buffer_line_t line;  // valid, code, address, size
  tag_t                 tag;   // tag claimed with this line

  modport arbiter (
    output line,
    output tag
  );

  modport control (
    input line,
    input tag
  );

endinterface

`default_nettype wire

//--- logic/tag_pool.sv
`timescale 1ns/1ps
`default_nettype none

module tag_pool #(
  parameter int NUM_TAGS = 16
) (
  input  logic          clock,
  input  logic          rstn,
  input  logic          claim,          // from arbiter, same edge as grant
  input  afu_pkg::tag_t claim_tag,
  input  logic          release_valid,  // host response
  input  afu_pkg::tag_t release_tag,
  output afu_pkg::tag_t free_tag,
  output logic          tag_available
);
  import afu_pkg::*;

  logic [NUM_TAGS-1:0] busy;       // one bit per outstanding tag
  logic [NUM_TAGS-1:0] busy_next;

  //////////////////////////////////////////////////////////////////////
  // lowest free tag
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    free_tag = INVALID_TAG;  // nothing free
    // scan down so the lowest free index is the last one written
    for (int i = NUM_TAGS - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_tag = tag_t'(i);
      end
    end
  end

  assign tag_available = ~&busy;

  //////////////////////////////////////////////////////////////////////
  // claim and release
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    busy_next = busy;
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (release_valid && (release_tag == tag_t'(i))) begin
        busy_next[i] = 1'b0;  // retired by host
      end
      if (claim && (claim_tag == tag_t'(i))) begin
        busy_next[i] = 1'b1;  // handed to a command
      end
    end
  end

  // both take effect in one cycle, never on the same tag
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy <= '0;  // all tags free
    end
    else begin
      busy <= busy_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/command_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module command_arbiter #(
  parameter int NUM_TAGS = 16
) (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            enabled,
  input  logic [afu_pkg::NUM_SOURCES-1:0] request,
  input  afu_pkg::address_t               request_address [afu_pkg::NUM_SOURCES],
  input  afu_pkg::size_t                  request_size    [afu_pkg::NUM_SOURCES],
  input  afu_pkg::tag_t                   free_tag,
  input  logic                            tag_available,
  output logic [afu_pkg::NUM_SOURCES-1:0] grant,
  output logic                            claim,
  output afu_pkg::tag_t                   claim_tag,
  cmd_line_if.arbiter                     line
);
  import afu_pkg::*;

  logic [NUM_SOURCES-1:0] eligible;
  logic                   issue;
  request_source_t        sel;

  //////////////////////////////////////////////////////////////////////
  // selection
  //////////////////////////////////////////////////////////////////////

  // source granted last cycle still shows its request, skip it once
  assign eligible = request & ~grant;

  always_comb begin
    sel = RESTART_SOURCE;
    for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel = request_source_t'(i);  // lowest index wins
      end
    end
  end

  assign issue = enabled && tag_available && (|eligible);

  // pool marks the tag busy on the same edge the grant registers
  assign claim     = issue;
  assign claim_tag = free_tag;

  //////////////////////////////////////////////////////////////////////
  // grant and line registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      grant              <= '0;
      line.line.valid    <= 1'b0;
      line.line.command  <= INVALID;
      line.line.address  <= '0;
      line.line.size     <= '0;
      line.tag           <= INVALID_TAG;
    end
    else begin
      grant           <= issue ? (NUM_SOURCES'(1) << sel) : '0;  // one cycle pulse
      line.line.valid <= issue;
      if (issue) begin
        line.line.command <= SOURCE_CODE[sel];
        line.line.address <= request_address[sel];
        line.line.size    <= request_size[sel];
        line.tag          <= free_tag;  // tag free at the decision edge
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/command_control.sv
`timescale 1ns/1ps
`default_nettype none

module command_control (
  input  logic                               clock,
  input  logic                               rstn,
  cmd_line_if.control                        line,
  output afu_pkg::command_interface_output_t command_out
);
  import afu_pkg::*;

  logic          valid_q;
  command_code_t command_q;
  address_t      address_q;
  tag_t          tag_q;
  size_t         size_q;

  //////////////////////////////////////////////////////////////////////
  // command register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_q   <= 1'b0;
      command_q <= INVALID;
      address_q <= '0;
      tag_q     <= INVALID_TAG;
      size_q    <= '0;
    end
    else begin
      valid_q   <= line.line.valid;  // high for one cycle per grant
      command_q <= line.line.command;
      address_q <= line.line.address;
      tag_q     <= line.tag;
      size_q    <= line.line.size;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus output and parity
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    command_out.valid          = valid_q;
    command_out.command        = command_q;
    command_out.command_parity = odd_parity(address_t'(command_q));
    command_out.address        = address_q;
    command_out.address_parity = odd_parity(address_q);
    command_out.tag            = tag_q;
    command_out.tag_parity     = odd_parity(address_t'(tag_q));
    command_out.size           = size_q;
    command_out.abt            = STRICT;   // fixed abort mode
    command_out.context_handle = 16'h0000; // dedicated mode
  end

endmodule

`default_nettype wire

//--- logic/afu_command_top.sv
`timescale 1ns/1ps
`default_nettype none

module afu_command_top #(
  parameter int NUM_TAGS = 16  // 2 to 256
) (
  input  logic                               clock,
  input  logic                               rstn,
  input  logic                               enabled,
  input  logic [afu_pkg::NUM_SOURCES-1:0]    request,
  input  afu_pkg::address_t                  request_address [afu_pkg::NUM_SOURCES],
  input  afu_pkg::size_t                     request_size    [afu_pkg::NUM_SOURCES],
  output logic [afu_pkg::NUM_SOURCES-1:0]    grant,
  input  logic                               response_valid,  // done response
  input  afu_pkg::tag_t                      response_tag,
  output afu_pkg::command_interface_output_t command_out
);
  import afu_pkg::*;

  tag_t free_tag;
  logic tag_available;
  logic claim;
  tag_t claim_tag;

  cmd_line_if line_bus ();  // arbiter to control

  //////////////////////////////////////////////////////////////////////
  // tag pool
  //////////////////////////////////////////////////////////////////////

  tag_pool #(
    .NUM_TAGS (NUM_TAGS)
  ) tag_pool_inst (
    .clock         (clock),
    .rstn          (rstn),
    .claim         (claim),
    .claim_tag     (claim_tag),
    .release_valid (response_valid),  // host hands the tag back
    .release_tag   (response_tag),
    .free_tag      (free_tag),
    .tag_available (tag_available)
  );

  //////////////////////////////////////////////////////////////////////
  // arbiter and command stage
  //////////////////////////////////////////////////////////////////////

  command_arbiter #(
    .NUM_TAGS (NUM_TAGS)
  ) command_arbiter_inst (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .request         (request),
    .request_address (request_address),
    .request_size    (request_size),
    .free_tag        (free_tag),
    .tag_available   (tag_available),
    .grant           (grant),
    .claim           (claim),
    .claim_tag       (claim_tag),
    .line            (line_bus.arbiter)
  );

  command_control command_control_inst (
    .clock       (clock),
    .rstn        (rstn),
    .line        (line_bus.control),
    .command_out (command_out)  // two cycles after the request edge
  );

endmodule

`default_nettype wire

//--- tests/afu_command_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module afu_command_asserts (
  input logic                               clock,
  input logic                               rstn,
  input logic                               arbiter_side,  // bound into the arbiter
  input logic [afu_pkg::NUM_SOURCES-1:0]    grant,
  input logic                               tag_available,
  input logic                               claim,
  input logic                               output_side,   // bound into command control
  input afu_pkg::command_interface_output_t command_out
);

  grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
    arbiter_side |-> $onehot0(grant))
    else $error("more than one grant bit set");

  grant_needs_tag: assert property (@(posedge clock) disable iff (!rstn)
    arbiter_side && !tag_available |=> grant == '0)
    else $error("grant made with no tag available");

  claim_gives_grant: assert property (@(posedge clock) disable iff (!rstn)
    arbiter_side && claim |=> grant != '0)
    else $error("claim without a grant on the next edge");

  grant_needs_claim: assert property (@(posedge clock) disable iff (!rstn)
    arbiter_side && !claim |=> grant == '0)
    else $error("grant without a claim");

  // each field plus its parity bit holds an odd count of ones
  output_parity: assert property (@(posedge clock) disable iff (!rstn)
    output_side && command_out.valid |->
      (^{command_out.command, command_out.command_parity}) &&
      (^{command_out.address, command_out.address_parity}) &&
      (^{command_out.tag, command_out.tag_parity}))
    else $error("bad parity on a valid bus command");

endmodule

bind command_arbiter afu_command_asserts arbiter_checks (
  .clock (clock), .rstn (rstn), .arbiter_side (1'b1), .grant (grant),
  .tag_available (tag_available), .claim (claim), .output_side (1'b0), .command_out ('0)
);

bind command_control afu_command_asserts output_checks (
  .clock (clock), .rstn (rstn), .arbiter_side (1'b0), .grant ('0),
  .tag_available (1'b0), .claim (1'b0), .output_side (1'b1), .command_out (command_out)
);

`default_nettype wire

//--- tests/afu_command_tb.sv
`timescale 1ns/1ps
`default_nettype none

module afu_command_tb;
  import afu_pkg::*;

  localparam int NUM_TAGS       = 16;
  localparam int RUN_CYCLES     = 600;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 2 + 100;  // 1000, reset included

  logic                      clock;
  logic                      rstn;
  logic                      enabled;
  logic [NUM_SOURCES-1:0]    request;
  address_t                  request_address [NUM_SOURCES];
  size_t                     request_size    [NUM_SOURCES];
  logic [NUM_SOURCES-1:0]    grant;
  logic                      response_valid;
  tag_t                      response_tag;
  command_interface_output_t command_out;

  // reference model state
  logic [NUM_TAGS-1:0]       model_busy;   // claimed, not yet retired
  logic [NUM_TAGS-1:0]       issued;       // seen on the bus, waiting for response
  logic [NUM_SOURCES-1:0]    model_grant;
  logic [NUM_SOURCES-1:0]    served;       // grant seen one cycle ago
  command_interface_output_t exp_line;     // arbiter register
  command_interface_output_t exp_stage;    // command control register

  int seed;
  int off_count;
  int full_waits;
  int cycle_count = 0;
  int command_errors, grant_errors, tag_errors, other_errors;

  afu_command_top #(.NUM_TAGS(NUM_TAGS)) DUT (.*);

  always #4 clock = ~clock;  // 8 ns

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // expected values
  //////////////////////////////////////////////////////////////////////

  // 1 when the field has an even count of ones
  function automatic logic odd_fill(input logic [63:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) ones = ones + int'(v[i]);
    return (ones % 2) == 0;
  endfunction

  function automatic command_code_t code_for(input int source);
    case (source)
      0:       return RESTART;
      2:       return WRITE_NA;
      default: return READ_CL_NA;  // wed fetch and read
    endcase
  endfunction

  function automatic command_interface_output_t with_parity(input command_interface_output_t c);
    command_interface_output_t r;
    r = c;
    r.command_parity = odd_fill(64'(c.command));
    r.address_parity = odd_fill(c.address);
    r.tag_parity     = odd_fill(64'(c.tag));
    r.abt            = STRICT;
    r.context_handle = '0;
    return r;
  endfunction

  task automatic check_command(input string name, input command_interface_output_t exp,
                               input command_interface_output_t act);
    if (act !== exp) begin
      command_errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_grant(input string name, input logic [NUM_SOURCES-1:0] exp,
                             input logic [NUM_SOURCES-1:0] act);
    if (act !== exp) begin
      grant_errors++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      tag_errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // one clock edge of the DUT, on the inputs it just sampled
  task automatic step_model();
    logic [NUM_SOURCES-1:0] eligible;
    int sel;
    int free_index;
    logic issue;
    eligible   = request & ~model_grant;  // granted source masked once
    sel        = -1;
    free_index = -1;
    for (int i = NUM_SOURCES - 1; i >= 0; i--) if (eligible[i]) sel = i;
    for (int t = NUM_TAGS - 1; t >= 0; t--) if (!model_busy[t]) free_index = t;
    issue = enabled && (sel >= 0) && (free_index >= 0);
    if (enabled && (eligible != '0) && (free_index < 0)) full_waits++;
    exp_stage      = exp_line;
    exp_line.valid = issue;
    model_grant    = '0;
    if (response_valid) model_busy[int'(response_tag)] = 1'b0;
    if (issue) begin
      exp_line.command       = code_for(sel);
      exp_line.address       = request_address[sel];
      exp_line.size          = request_size[sel];
      exp_line.tag           = tag_t'(free_index);
      model_grant[sel]       = 1'b1;
      model_busy[free_index] = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs(input int cycle);
    int start;
    int t;
    response_valid = 1'b0;
    // no responses in the middle window, pool runs dry there
    if ((cycle < 200 || cycle >= 300) && ($random(seed) % 3 == 0)) begin
      start = $random(seed) & 15;
      for (int k = 0; k < NUM_TAGS; k++) begin
        t = (start + k) % NUM_TAGS;
        if (!response_valid && issued[t]) begin
          response_valid = 1'b1;
          response_tag   = tag_t'(t);
          issued[t]      = 1'b0;
        end
      end
    end
    if (off_count > 0) begin
      off_count--;
      if (off_count == 0) enabled = 1'b1;
    end
    else if (($random(seed) & 31) == 0) begin
      enabled   = 1'b0;  // random stretch of 1 to 8 cycles
      off_count = 1 + ($random(seed) & 7);
    end
    for (int s = 0; s < NUM_SOURCES; s++) begin
      if (served[s]) request[s] = 1'b0;  // held through the grant cycle, drop now
      else if (!request[s] && (($random(seed) & 3) != 0)) begin
        request[s]         = 1'b1;
        request_address[s] = {$random(seed), $random(seed)};
        request_size[s]    = size_t'($random(seed));
      end
    end
    served = model_grant;
  endtask

  initial begin
    seed  = 32'h9f5b_5933;
    clock = 1'b0;
    rstn  = 1'b0;
    enabled        = 1'b0;
    request        = '0;
    response_valid = 1'b0;
    response_tag   = '0;
    for (int s = 0; s < NUM_SOURCES; s++) begin
      request_address[s] = '0;
      request_size[s]    = '0;
    end
    model_busy  = '0;
    issued      = '0;
    model_grant = '0;
    served      = '0;
    exp_line    = '0;
    exp_line.command = INVALID;
    exp_line.tag     = INVALID_TAG;
    exp_stage   = exp_line;
    off_count   = 0;
    full_waits  = 0;
    command_errors = 0;
    grant_errors   = 0;
    tag_errors     = 0;
    other_errors   = 0;

    repeat (2) @(posedge clock);
    #1;
    rstn    = 1'b1;
    enabled = 1'b1;
    check_grant("reset grant", '0, grant);
    check_command("reset command_out", with_parity(exp_stage), command_out);
    check_tag("reset tag", INVALID_TAG, command_out.tag);

    for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      @(posedge clock);
      step_model();
      #1;  // registered outputs settled
      check_grant("grant", model_grant, grant);
      check_command("command_out", with_parity(exp_stage), command_out);
      if (exp_stage.valid) begin
        check_tag("issued tag", exp_stage.tag, command_out.tag);
        if (issued[int'(exp_stage.tag)]) begin
          other_errors++;
          $display("tag %0d issued again before its response", exp_stage.tag);
        end
        issued[int'(exp_stage.tag)] = 1'b1;
      end
      drive_inputs(cycle);
    end

    if (full_waits == 0) begin
      other_errors++;
      $display("the tag pool never ran out of tags during the run");
    end
    $display("errors: command %0d, grant %0d, tag %0d, other %0d",
             command_errors, grant_errors, tag_errors, other_errors);
    if (command_errors + grant_errors + tag_errors + other_errors == 0) begin
      $display("TESTS PASSED");
    end
    else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/afu_pkg.sv
logic/cmd_line_if.sv
logic/tag_pool.sv
logic/command_arbiter.sv
logic/command_control.sv
logic/afu_command_top.sv
tests/afu_command_asserts.sv
tests/afu_command_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module afu_command_tb \
  -f sources.f --Mdir obj_dir -o afu_command_sim > build.log 2>&1 \
  && ./obj_dir/afu_command_sim > sim.log 2>&1

grep -q "^TESTS PASSED$" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
